//--- Bender.yml
package:
  name: rvv_rob

sources:
  - include_dirs:
      - src
    files:
      - src/rob_uop_pkg.sv
      - src/rob_res_pkg.sv
      - src/multi_fifo.sv
      - src/rob_result_tracker.sv
      - src/rob_retire_sel.sv
      - src/rvv_rob.sv
  - target: test
    include_dirs:
      - src
    files:
      - bench/rvv_rob_assert.sv
      - bench/rvv_rob_tb.sv

//--- bench/rvv_rob_assert.sv
// rvv_rob_assert follows the reorder buffer with a shadow model and checks it by assertions
`timescale 1ns/100ps
`include "rob_cfg.svh"

module rvv_rob_assert
  import rob_uop_pkg::*;
  import rob_res_pkg::*;
(
  input logic                         clk,
  input logic                         rst_n,
  input logic       [`NUM_DP_UOP-1:0] uop_valid_dp2rob,
  input dp2rob_t    [`NUM_DP_UOP-1:0] uop_dp2rob,
  input logic       [`NUM_DP_UOP-1:0] uop_ready_rob2dp,
  input rob_entry_t                   uop_index_rob2dp,
  input logic       [`NUM_ALU-1:0]    wr_valid_alu2rob,
  input pu2rob_t    [`NUM_ALU-1:0]    wr_alu2rob,
  input logic       [`NUM_MUL-1:0]    wr_valid_mul2rob,
  input pu2rob_t    [`NUM_MUL-1:0]    wr_mul2rob,
  input logic       [`NUM_LSU-1:0]    wr_valid_lsu2rob,
  input pu2rob_t    [`NUM_LSU-1:0]    wr_lsu2rob,
  input logic       [`NUM_RT_UOP-1:0] rd_valid_rob2rt,
  input rob2rt_t    [`NUM_RT_UOP-1:0] rd_rob2rt,
  input logic       [`NUM_RT_UOP-1:0] rd_ready_rt2rob,
  input rob2dp_t    [`ROB_DEPTH-1:0]  uop_rob2dp,
  input logic                         trap_valid_rvs2rvv,
  input rob_entry_t                   trap_entry_rvs2rvv
);

  localparam int NUM_PU = `NUM_ALU + `NUM_MUL + `NUM_LSU;

  int unsigned errs = 0;

  // shadow state, program order starts at sh_head
  rob_entry_t                  sh_head;
  int                          sh_cnt;
  dp2rob_t                     sh_info [`ROB_DEPTH];
  res_entry_t                  sh_res  [`ROB_DEPTH];
  logic       [`ROB_DEPTH-1:0] sh_done;
  logic       [`ROB_DEPTH-1:0] sh_trap;

  logic       [NUM_PU-1:0]      pu_valid;
  pu2rob_t    [NUM_PU-1:0]      pu_res;
  rob_entry_t                   exp_index;
  logic       [`NUM_DP_UOP-1:0] exp_ready;
  logic       [`NUM_RT_UOP-1:0] exp_valid;
  rob2rt_t    [`NUM_RT_UOP-1:0] exp_rt;
  rob2dp_t    [`ROB_DEPTH-1:0]  exp_view;
  rob2dp_t    [`ROB_DEPTH-1:0]  act_view;

  assign pu_valid  = {wr_valid_lsu2rob, wr_valid_mul2rob, wr_valid_alu2rob};
  assign pu_res    = {wr_lsu2rob, wr_mul2rob, wr_alu2rob};
  assign exp_index = sh_head + rob_entry_t'(sh_cnt);

  always_comb begin : expected_outputs
    rob_entry_t e;
    logic       v;
    logic       older_ok;
    older_ok = 1'b1;
    for (int i = 0; i < `NUM_DP_UOP; i++) begin
      exp_ready[i] = (`ROB_DEPTH - sh_cnt) > i;
    end
    for (int k = 0; k < `NUM_RT_UOP; k++) begin
      e = sh_head + rob_entry_t'(k);
      // in order, a trapped micro-op closes the group
      v            = older_ok && (k < sh_cnt) && sh_done[e];
      older_ok     = v && !sh_trap[e];
      exp_valid[k] = v;
      exp_rt[k] = '{
        w_valid:        sh_res[e].w_valid & v,
        w_index:        sh_info[e].w_index,
        w_data:         sh_res[e].w_data,
        w_type:         sh_info[e].w_type,
        vd_type:        sh_info[e].byte_type,
        trap_flag:      sh_trap[e],
        vector_csr:     sh_info[e].vector_csr,
        vxsat:          sh_res[e].vxsat,
        last_uop_valid: sh_info[e].last_uop_valid
      };
    end
    // data of a slot without result is not compared
    for (int i = 0; i < `ROB_DEPTH; i++) begin
      e = sh_head + rob_entry_t'(i);
      exp_view[i] = '{
        valid:      i < sh_cnt,
        w_valid:    sh_res[e].w_valid & sh_done[e],
        w_index:    sh_info[e].w_index,
        w_data:     sh_done[e] ? sh_res[e].w_data : '0,
        byte_type:  sh_info[e].byte_type,
        vector_csr: sh_info[e].vector_csr
      };
      act_view[i] = uop_rob2dp[i];
      if (!sh_done[e]) begin
        act_view[i].w_data = '0;
      end
    end
  end

  always @(posedge clk or negedge rst_n) begin : shadow_update
    int         pops;
    int         pushes;
    logic       flush;
    rob_entry_t tail;
    if (!rst_n) begin
      sh_head <= '0;
      sh_cnt  <= 0;
      sh_done <= '0;
      sh_trap <= '0;
    end else begin
      pops   = 0;
      pushes = 0;
      flush  = 1'b0;
      tail   = exp_index;
      for (int k = 0; k < `NUM_RT_UOP; k++) begin
        if (exp_valid[k] && rd_ready_rt2rob[k]) begin
          pops++;
          flush = flush | sh_trap[sh_head + rob_entry_t'(k)];
          sh_done[sh_head + rob_entry_t'(k)] <= 1'b0;
        end
      end
      for (int i = 0; i < `NUM_DP_UOP; i++) begin
        if (uop_valid_dp2rob[i] && exp_ready[i]) begin
          sh_info[tail] <= uop_dp2rob[i];
          tail = tail + 1'b1;
          pushes++;
        end
      end
      for (int p = 0; p < NUM_PU; p++) begin
        if (pu_valid[p]) begin
          sh_res[pu_res[p].rob_entry]  <= '{pu_res[p].w_valid, pu_res[p].w_data,
                                            pu_res[p].vxsat};
          sh_done[pu_res[p].rob_entry] <= 1'b1;
        end
      end
      if (trap_valid_rvs2rvv) begin
        sh_trap[trap_entry_rvs2rvv] <= 1'b1;
      end
      sh_head <= sh_head + rob_entry_t'(pops);
      sh_cnt  <= sh_cnt + pushes - pops;
      // popping the trapped entry empties everything
      if (flush) begin
        sh_head <= '0;
        sh_cnt  <= 0;
        sh_done <= '0;
        sh_trap <= '0;
      end
    end
  end

  a_dp_ready: assert property (@(posedge clk) disable iff (!rst_n)
    uop_ready_rob2dp == exp_ready)
    else begin
      $error("Error uop_ready_rob2dp exp %h got %h",
             $sampled(exp_ready), $sampled(uop_ready_rob2dp));
      errs++;
    end

  a_dp_index: assert property (@(posedge clk) disable iff (!rst_n)
    uop_index_rob2dp == exp_index)
    else begin
      $error("Error uop_index_rob2dp exp %h got %h",
             $sampled(exp_index), $sampled(uop_index_rob2dp));
      errs++;
    end

  a_rt_valid: assert property (@(posedge clk) disable iff (!rst_n)
    rd_valid_rob2rt == exp_valid)
    else begin
      $error("Error rd_valid_rob2rt exp %h got %h",
             $sampled(exp_valid), $sampled(rd_valid_rob2rt));
      errs++;
    end

  // stalled head keeps its record
  a_rt_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rd_valid_rob2rt[0] && !rd_ready_rt2rob[0] |=>
    rd_valid_rob2rt[0] && $stable(rd_rob2rt[0]))
    else begin
      $error("retire head dropped or changed while retire was stalled");
      errs++;
    end

  for (genvar k = 0; k < `NUM_RT_UOP; k++) begin : g_lane
    a_rt_rec: assert property (@(posedge clk) disable iff (!rst_n)
      exp_valid[k] ? (rd_rob2rt[k] == exp_rt[k]) : !rd_rob2rt[k].w_valid)
      else begin
        $error("Error rd_rob2rt[%0d] exp %h got %h",
               k, $sampled(exp_rt[k]), $sampled(rd_rob2rt[k]));
        errs++;
      end
  end

  for (genvar i = 0; i < `ROB_DEPTH; i++) begin : g_slot
    a_view: assert property (@(posedge clk) disable iff (!rst_n)
      exp_view[i].valid ? (act_view[i] == exp_view[i]) : !uop_rob2dp[i].valid)
      else begin
        $error("Error uop_rob2dp[%0d] exp %h got %h",
               i, $sampled(exp_view[i]), $sampled(act_view[i]));
        errs++;
      end
  end

endmodule

bind rvv_rob rvv_rob_assert u_chk (.*);

//--- bench/rvv_rob_tb.sv
// rvv_rob_tb drives dispatch, unit results, traps and retire of the reorder buffer
`timescale 1ns/100ps
`include "rob_cfg.svh"

module rvv_rob_tb
  import rob_uop_pkg::*;
  import rob_res_pkg::*;
();

  localparam real CLK_PERIOD  = 4.0;
  localparam int  NUM_TESTS   = 3;
  localparam int  RAND_CYCLES = 150;
  localparam int  NUM_PU      = `NUM_ALU + `NUM_MUL + `NUM_LSU;
  localparam int  DPW         = $bits(dp2rob_t);

  logic                         clk;
  logic                         rst_n;
  logic       [`NUM_DP_UOP-1:0] uop_valid_dp2rob;
  dp2rob_t    [`NUM_DP_UOP-1:0] uop_dp2rob;
  logic       [`NUM_DP_UOP-1:0] uop_ready_rob2dp;
  rob_entry_t                   uop_index_rob2dp;
  logic       [`NUM_ALU-1:0]    wr_valid_alu2rob;
  pu2rob_t    [`NUM_ALU-1:0]    wr_alu2rob;
  logic       [`NUM_MUL-1:0]    wr_valid_mul2rob;
  pu2rob_t    [`NUM_MUL-1:0]    wr_mul2rob;
  logic       [`NUM_LSU-1:0]    wr_valid_lsu2rob;
  pu2rob_t    [`NUM_LSU-1:0]    wr_lsu2rob;
  logic       [`NUM_RT_UOP-1:0] rd_valid_rob2rt;
  rob2rt_t    [`NUM_RT_UOP-1:0] rd_rob2rt;
  logic       [`NUM_RT_UOP-1:0] rd_ready_rt2rob;
  rob2dp_t    [`ROB_DEPTH-1:0]  uop_rob2dp;
  logic                         trap_valid_rvs2rvv;
  rob_entry_t                   trap_entry_rvs2rvv;

  int         seed;
  // dispatched entries still waiting for their result
  rob_entry_t pend [$];

  rvv_rob i_dut (.*);

  initial begin : clock_gen
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  task automatic drive_result(input int p, input rob_entry_t e);
    pu2rob_t r;
    r.rob_entry = e;
    r.w_valid   = 1'($random(seed));
    r.w_data    = $random(seed);
    r.vxsat     = 1'($random(seed));
    if (p < `NUM_ALU) begin
      wr_valid_alu2rob[p] = 1'b1;
      wr_alu2rob[p]       = r;
    end else if (p < `NUM_ALU + `NUM_MUL) begin
      wr_valid_mul2rob[p - `NUM_ALU] = 1'b1;
      wr_mul2rob[p - `NUM_ALU]       = r;
    end else begin
      wr_valid_lsu2rob[p - `NUM_ALU - `NUM_MUL] = 1'b1;
      wr_lsu2rob[p - `NUM_ALU - `NUM_MUL]       = r;
    end
  endtask

  // one falling edge worth of stimulus
  task automatic cycle_drive(input int n_dp, input int n_res, input logic [3:0] ready);
    int j;
    int n;
    @(negedge clk);
    wr_valid_alu2rob   = '0;
    wr_valid_mul2rob   = '0;
    wr_valid_lsu2rob   = '0;
    trap_valid_rvs2rvv = 1'b0;
    // results only for entries dispatched earlier, each one once
    n = (n_res < pend.size()) ? n_res : pend.size();
    for (int p = 0; p < n; p++) begin
      j = $unsigned($random(seed)) % pend.size();
      drive_result(p, pend[j]);
      pend.delete(j);
    end
    uop_valid_dp2rob = `NUM_DP_UOP'((1 << n_dp) - 1);
    for (int i = 0; i < `NUM_DP_UOP; i++) begin
      uop_dp2rob[i] = DPW'($random(seed));
      if (i < n_dp && uop_ready_rob2dp[i]) begin
        pend.push_back(uop_index_rob2dp + rob_entry_t'(i));
      end
    end
    rd_ready_rt2rob = ready;
  endtask

  // complete and retire everything until the view is empty
  task automatic drain();
    cycle_drive(0, NUM_PU, '1);
    while (uop_rob2dp[0].valid) begin
      cycle_drive(0, NUM_PU, '1);
    end
  endtask

  initial begin : watchdog
    #(NUM_TESTS * 200 * CLK_PERIOD);
    $display("TEST FAIL");
    $fatal(1, "timeout, the stimulus did not finish in time");
  end

  initial begin : error_watch
    wait (i_dut.u_chk.errs != 0);
    $display("TEST FAIL");
    $fatal(1, "stopping at the first failed check");
  end

  initial begin : stimulus
    seed               = 32'hc14e33de;
    rst_n              = 1'b0;
    uop_valid_dp2rob   = '0;
    uop_dp2rob         = '0;
    wr_valid_alu2rob   = '0;
    wr_alu2rob         = '0;
    wr_valid_mul2rob   = '0;
    wr_mul2rob         = '0;
    wr_valid_lsu2rob   = '0;
    wr_lsu2rob         = '0;
    rd_ready_rt2rob    = '0;
    trap_valid_rvs2rvv = 1'b0;
    trap_entry_rvs2rvv = '0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // fill all entries with retire held off, then complete out of order
    repeat (4) cycle_drive(2, 0, '0);
    cycle_drive(2, 0, '0);
    repeat (2) cycle_drive(0, NUM_PU, '0);
    repeat (3) cycle_drive(0, 0, '0);
    cycle_drive(0, 0, 4'b0001);
    cycle_drive(0, 0, '0);
    drain();

    // trap on the second of four micro-ops
    cycle_drive(2, 0, '0);
    trap_valid_rvs2rvv = 1'b1;
    trap_entry_rvs2rvv = pend[1];
    cycle_drive(2, 0, '0);
    cycle_drive(0, NUM_PU, '0);
    repeat (2) cycle_drive(0, 0, '0);
    drain();

    // random traffic, ready always a prefix
    repeat (RAND_CYCLES) begin
      cycle_drive($unsigned($random(seed)) % 3, $unsigned($random(seed)) % 5,
                  4'((1 << ($unsigned($random(seed)) % 5)) - 1));
    end
    drain();

    repeat (2) @(negedge clk);
    if (i_dut.u_chk.errs == 0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      $display("TEST FAIL");
      $fatal(1, "the bound checker reported %0d failures", i_dut.u_chk.errs);
    end
  end

endmodule

//--- rvv_rob.f
+incdir+src
src/rob_uop_pkg.sv
src/rob_res_pkg.sv
src/multi_fifo.sv
src/rob_result_tracker.sv
src/rob_retire_sel.sv
src/rvv_rob.sv
bench/rvv_rob_assert.sv
bench/rvv_rob_tb.sv

//--- src/multi_fifo.sv
// multi_fifo circular buffer with multi-lane push and pop over any payload type
`timescale 1ns/100ps

module multi_fifo #(
  parameter type T         = logic,
  parameter int  M         = 2,
  parameter int  N         = 4,
  parameter int  DEPTH     = 8,
  parameter bit  POP_CLEAR = 1'b0
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [M-1:0]               push,
  input  T     [M-1:0]               datain,
  output logic [M-1:0]               push_ready,
  input  logic [N-1:0]               pop,
  output T     [N-1:0]               dataout,
  input  logic                       clear,
  output T     [DEPTH-1:0]           fifo_data,
  output logic [$clog2(DEPTH)-1:0]   wptr,
  output logic [$clog2(DEPTH)-1:0]   rptr
);

  localparam int AW = $clog2(DEPTH);
  localparam int CW = $clog2(DEPTH + 1);

  T     [DEPTH-1:0] mem;
  T     [DEPTH-1:0] mem_next;
  logic [CW-1:0]    count;
  logic [CW-1:0]    free_cnt;
  logic [M-1:0]     push_acc;
  logic [CW-1:0]    push_cnt;
  logic [CW-1:0]    pop_cnt;

  // lane i may push while more than i entries are free
  assign free_cnt = CW'(DEPTH) - count;

  for (genvar i = 0; i < M; i++) begin : g_ready
    assign push_ready[i] = (free_cnt > CW'(i));
  end

  assign push_acc = push & push_ready;

  always_comb begin : count_lanes
    push_cnt = '0;
    pop_cnt  = '0;
    for (int i = 0; i < M; i++) begin
      push_cnt = push_cnt + CW'(push_acc[i]);
    end
    for (int k = 0; k < N; k++) begin
      pop_cnt = pop_cnt + CW'(pop[k]);
    end
  end

  // accepted lanes land in consecutive entries from wptr
  always_comb begin : next_contents
    logic [AW-1:0] waddr;
    mem_next = mem;
    waddr    = wptr;
    if (POP_CLEAR) begin
      for (int k = 0; k < N; k++) begin
        if (pop[k]) begin
          mem_next[rptr + AW'(k)] = '0;
        end
      end
    end
    for (int i = 0; i < M; i++) begin
      if (push_acc[i]) begin
        mem_next[waddr] = datain[i];
        waddr           = waddr + 1'b1;
      end
    end
    if (clear) begin
      mem_next = '0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else if (clear) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      wptr  <= wptr + AW'(push_cnt);
      rptr  <= rptr + AW'(pop_cnt);
      count <= count + push_cnt - pop_cnt;
    end
  end

  // entry storage
  if (POP_CLEAR) begin : g_mem_rst
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        mem <= '0;
      end else begin
        mem <= mem_next;
      end
    end
  end else begin : g_mem
    always_ff @(posedge clk) begin
      mem <= mem_next;
    end
  end

  // head-relative view of the next N entries
  for (genvar k = 0; k < N; k++) begin : g_dout
    assign dataout[k] = mem[rptr + AW'(k)];
  end

  assign fifo_data = mem;

endmodule

//--- src/rob_cfg.svh
// rob configuration macros for lane counts, buffer depth and result data width
`ifndef ROB_CFG_SVH
`define ROB_CFG_SVH

// micro-ops accepted from dispatch per cycle
`define NUM_DP_UOP 2

// micro-ops retired per cycle
`define NUM_RT_UOP 4

// buffer entries and entry index width
`define ROB_DEPTH 8
`define ROB_DEPTH_WIDTH 3

// result ports per unit group
`define NUM_ALU 2
`define NUM_MUL 1
`define NUM_LSU 1

// width of one result word
`define VLEN_DATA 32

`endif

//--- src/rob_res_pkg.sv
// rob_res_pkg holds the result, retire record and trap types of the reorder buffer
`include "rob_cfg.svh"

package rob_res_pkg;

  import rob_uop_pkg::*;

  // entry index, also used to name the trapped entry
  typedef logic [`ROB_DEPTH_WIDTH-1:0] rob_entry_t;

  // result written back by a processing unit
  typedef struct packed {
    rob_entry_t rob_entry;
    logic       w_valid;
    w_data_t    w_data;
    logic       vxsat;
  } pu2rob_t;

  // result as kept per entry
  typedef struct packed {
    logic    w_valid;
    w_data_t w_data;
    logic    vxsat;
  } res_entry_t;

  // record handed to the retire unit
  typedef struct packed {
    logic       w_valid;
    w_index_t   w_index;
    w_data_t    w_data;
    logic       w_type;
    byte_type_t vd_type;        // byte type of the destination
    logic       trap_flag;
    vcsr_t      vector_csr;
    logic       vxsat;
    logic       last_uop_valid;
  } rob2rt_t;

endpackage

//--- src/rob_result_tracker.sv
// rob_result_tracker keeps unit results, done bits and trap flags per buffer entry
`timescale 1ns/100ps
`include "rob_cfg.svh"

module rob_result_tracker
  import rob_res_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic       [`NUM_ALU-1:0]    wr_valid_alu2rob,
  input  pu2rob_t    [`NUM_ALU-1:0]    wr_alu2rob,
  input  logic       [`NUM_MUL-1:0]    wr_valid_mul2rob,
  input  pu2rob_t    [`NUM_MUL-1:0]    wr_mul2rob,
  input  logic       [`NUM_LSU-1:0]    wr_valid_lsu2rob,
  input  pu2rob_t    [`NUM_LSU-1:0]    wr_lsu2rob,
  input  logic                         trap_valid_rvs2rvv,
  input  rob_entry_t                   trap_entry_rvs2rvv,
  input  logic       [`NUM_RT_UOP-1:0] retire_pop,
  input  rob_entry_t                   rptr,
  input  logic                         flush_rob,
  output res_entry_t [`ROB_DEPTH-1:0]  res_mem,
  output logic       [`ROB_DEPTH-1:0]  uop_done,
  output logic       [`ROB_DEPTH-1:0]  trap_flag
);

  localparam int NUM_PU = `NUM_ALU + `NUM_MUL + `NUM_LSU;
  localparam int AW     = $bits(rob_entry_t);

  logic    [NUM_PU-1:0] pu_valid;
  pu2rob_t [NUM_PU-1:0] pu_res;

  // all result ports as one list, alu in the low lanes
  assign pu_valid = {wr_valid_lsu2rob, wr_valid_mul2rob, wr_valid_alu2rob};
  assign pu_res   = {wr_lsu2rob, wr_mul2rob, wr_alu2rob};

  // result storage, at most one writer per entry and cycle
  always_ff @(posedge clk) begin
    for (int p = 0; p < NUM_PU; p++) begin
      if (pu_valid[p]) begin
        res_mem[pu_res[p].rob_entry] <= '{
          w_valid: pu_res[p].w_valid,
          w_data:  pu_res[p].w_data,
          vxsat:   pu_res[p].vxsat
        };
      end
    end
  end

  // done goes low as the head entries retire, high on result write
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      uop_done <= '0;
    end else if (flush_rob) begin
      uop_done <= '0;
    end else begin
      for (int k = 0; k < `NUM_RT_UOP; k++) begin
        if (retire_pop[k]) begin
          uop_done[rptr + AW'(k)] <= 1'b0;
        end
      end
      for (int p = 0; p < NUM_PU; p++) begin
        if (pu_valid[p]) begin
          uop_done[pu_res[p].rob_entry] <= 1'b1;
        end
      end
    end
  end

  // a trapped entry stays marked until its retirement flushes the buffer
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      trap_flag <= '0;
    end else if (flush_rob) begin
      trap_flag <= '0;
    end else if (trap_valid_rvs2rvv) begin
      trap_flag[trap_entry_rvs2rvv] <= 1'b1;
    end
  end

endmodule

//--- src/rob_retire_sel.sv
// rob_retire_sel builds the in-order retire lanes, the flush and the dispatch view
`timescale 1ns/100ps
`include "rob_cfg.svh"

module rob_retire_sel
  import rob_uop_pkg::*;
  import rob_res_pkg::*;
(
  input  dp2rob_t    [`ROB_DEPTH-1:0]  info_data,
  input  logic       [`ROB_DEPTH-1:0]  entry_valid,
  input  rob_entry_t                   rptr,
  input  res_entry_t [`ROB_DEPTH-1:0]  res_mem,
  input  logic       [`ROB_DEPTH-1:0]  uop_done,
  input  logic       [`ROB_DEPTH-1:0]  trap_flag,
  input  logic       [`NUM_RT_UOP-1:0] rd_ready_rt2rob,
  output logic       [`NUM_RT_UOP-1:0] rd_valid_rob2rt,
  output rob2rt_t    [`NUM_RT_UOP-1:0] rd_rob2rt,
  output logic       [`NUM_RT_UOP-1:0] retire_pop,
  output logic                         flush_rob,
  output rob2dp_t    [`ROB_DEPTH-1:0]  uop_rob2dp
);

  localparam int AW = $bits(rob_entry_t);

  // entry index of each head-relative slot
  rob_entry_t                   slot_idx [`ROB_DEPTH];
  logic       [`NUM_RT_UOP-1:0] rt_ready;
  logic       [`NUM_RT_UOP-1:0] rt_trap_pop;

  for (genvar i = 0; i < `ROB_DEPTH; i++) begin : g_slot
    assign slot_idx[i] = rptr + AW'(i);
  end

  for (genvar k = 0; k < `NUM_RT_UOP; k++) begin : g_rt
    // occupied and written back
    assign rt_ready[k] = entry_valid[slot_idx[k]] & uop_done[slot_idx[k]];

    if (k == 0) begin : g_head
      assign rd_valid_rob2rt[k] = rt_ready[k];
    end else begin : g_tail
      // nothing younger than a trapped micro-op leaves in the same group
      assign rd_valid_rob2rt[k] = rt_ready[k] & rd_valid_rob2rt[k-1]
                                & ~trap_flag[slot_idx[k-1]];
    end

    assign rd_rob2rt[k] = '{
      w_valid:        res_mem[slot_idx[k]].w_valid & rd_valid_rob2rt[k],
      w_index:        info_data[slot_idx[k]].w_index,
      w_data:         res_mem[slot_idx[k]].w_data,
      w_type:         info_data[slot_idx[k]].w_type,
      vd_type:        info_data[slot_idx[k]].byte_type,
      trap_flag:      trap_flag[slot_idx[k]],
      vector_csr:     info_data[slot_idx[k]].vector_csr,
      vxsat:          res_mem[slot_idx[k]].vxsat,
      last_uop_valid: info_data[slot_idx[k]].last_uop_valid
    };

    assign rt_trap_pop[k] = trap_flag[slot_idx[k]] & retire_pop[k];
  end

  assign retire_pop = rd_valid_rob2rt & rd_ready_rt2rob;

  // retiring the trapped micro-op empties the whole buffer
  assign flush_rob = |rt_trap_pop;

  // forwarding view, slot 0 is the oldest entry
  for (genvar i = 0; i < `ROB_DEPTH; i++) begin : g_dp
    assign uop_rob2dp[i] = '{
      valid:      entry_valid[slot_idx[i]],
      w_valid:    res_mem[slot_idx[i]].w_valid & uop_done[slot_idx[i]],
      w_index:    info_data[slot_idx[i]].w_index,
      w_data:     res_mem[slot_idx[i]].w_data,
      byte_type:  info_data[slot_idx[i]].byte_type,
      vector_csr: info_data[slot_idx[i]].vector_csr
    };
  end

endmodule

//--- src/rob_uop_pkg.sv
// rob_uop_pkg holds the micro-op types exchanged between dispatch and the reorder buffer
`include "rob_cfg.svh"

package rob_uop_pkg;

  // destination register index
  typedef logic [4:0] w_index_t;

  // byte enables of the destination element group
  typedef logic [3:0] byte_type_t;

  // vector csr snapshot taken at dispatch
  typedef logic [7:0] vcsr_t;

  // result word, shared with the result side
  typedef logic [`VLEN_DATA-1:0] w_data_t;

  // micro-op as written by dispatch
  typedef struct packed {
    w_index_t   w_index;
    logic       w_type;         // 0 vector rf, 1 scalar rf
    byte_type_t byte_type;
    vcsr_t      vector_csr;
    logic       last_uop_valid;
  } dp2rob_t;

  // one slot of the operand forwarding view, program order
  typedef struct packed {
    logic       valid;
    logic       w_valid;
    w_index_t   w_index;
    w_data_t    w_data;
    byte_type_t byte_type;
    vcsr_t      vector_csr;
  } rob2dp_t;

endpackage

//--- src/rvv_rob.sv
// rvv_rob reorder buffer of the vector backend, in-order retire of out-of-order results
`timescale 1ns/100ps
`include "rob_cfg.svh"

module rvv_rob
  import rob_uop_pkg::*;
  import rob_res_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst_n,
  // dispatch
  input  logic       [`NUM_DP_UOP-1:0] uop_valid_dp2rob,
  input  dp2rob_t    [`NUM_DP_UOP-1:0] uop_dp2rob,
  output logic       [`NUM_DP_UOP-1:0] uop_ready_rob2dp,
  output rob_entry_t                   uop_index_rob2dp,
  // unit results
  input  logic       [`NUM_ALU-1:0]    wr_valid_alu2rob,
  input  pu2rob_t    [`NUM_ALU-1:0]    wr_alu2rob,
  input  logic       [`NUM_MUL-1:0]    wr_valid_mul2rob,
  input  pu2rob_t    [`NUM_MUL-1:0]    wr_mul2rob,
  input  logic       [`NUM_LSU-1:0]    wr_valid_lsu2rob,
  input  pu2rob_t    [`NUM_LSU-1:0]    wr_lsu2rob,
  // retire
  output logic       [`NUM_RT_UOP-1:0] rd_valid_rob2rt,
  output rob2rt_t    [`NUM_RT_UOP-1:0] rd_rob2rt,
  input  logic       [`NUM_RT_UOP-1:0] rd_ready_rt2rob,
  // operand forwarding view
  output rob2dp_t    [`ROB_DEPTH-1:0]  uop_rob2dp,
  // trap
  input  logic                         trap_valid_rvs2rvv,
  input  rob_entry_t                   trap_entry_rvs2rvv
);

  dp2rob_t    [`ROB_DEPTH-1:0]  info_data;
  logic       [`ROB_DEPTH-1:0]  entry_valid;
  rob_entry_t                   rob_rptr;
  res_entry_t [`ROB_DEPTH-1:0]  res_mem;
  logic       [`ROB_DEPTH-1:0]  uop_done;
  logic       [`ROB_DEPTH-1:0]  trap_flag;
  logic       [`NUM_RT_UOP-1:0] retire_pop;
  logic                         flush_rob;

  // micro-op info in program order, write pointer is the next entry index
  multi_fifo #(
    .T         (dp2rob_t),
    .M         (`NUM_DP_UOP),
    .N         (`NUM_RT_UOP),
    .DEPTH     (`ROB_DEPTH),
    .POP_CLEAR (1'b0)
  ) u_info_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .push       (uop_valid_dp2rob),
    .datain     (uop_dp2rob),
    .push_ready (uop_ready_rob2dp),
    .pop        (retire_pop),
    .dataout    (),
    .clear      (flush_rob),
    .fifo_data  (info_data),
    .wptr       (uop_index_rob2dp),
    .rptr       (rob_rptr)
  );

  // occupancy bit per entry, set on push and zeroed on pop
  multi_fifo #(
    .T         (logic),
    .M         (`NUM_DP_UOP),
    .N         (`NUM_RT_UOP),
    .DEPTH     (`ROB_DEPTH),
    .POP_CLEAR (1'b1)
  ) u_valid_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .push       (uop_valid_dp2rob),
    .datain     (uop_valid_dp2rob),
    .push_ready (),
    .pop        (retire_pop),
    .dataout    (),
    .clear      (flush_rob),
    .fifo_data  (entry_valid),
    .wptr       (),
    .rptr       ()
  );

  rob_result_tracker u_tracker (
    .clk                (clk),
    .rst_n              (rst_n),
    .wr_valid_alu2rob   (wr_valid_alu2rob),
    .wr_alu2rob         (wr_alu2rob),
    .wr_valid_mul2rob   (wr_valid_mul2rob),
    .wr_mul2rob         (wr_mul2rob),
    .wr_valid_lsu2rob   (wr_valid_lsu2rob),
    .wr_lsu2rob         (wr_lsu2rob),
    .trap_valid_rvs2rvv (trap_valid_rvs2rvv),
    .trap_entry_rvs2rvv (trap_entry_rvs2rvv),
    .retire_pop         (retire_pop),
    .rptr               (rob_rptr),
    .flush_rob          (flush_rob),
    .res_mem            (res_mem),
    .uop_done           (uop_done),
    .trap_flag          (trap_flag)
  );

  rob_retire_sel u_retire_sel (
    .info_data       (info_data),
    .entry_valid     (entry_valid),
    .rptr            (rob_rptr),
    .res_mem         (res_mem),
    .uop_done        (uop_done),
    .trap_flag       (trap_flag),
    .rd_ready_rt2rob (rd_ready_rt2rob),
    .rd_valid_rob2rt (rd_valid_rob2rt),
    .rd_rob2rt       (rd_rob2rt),
    .retire_pop      (retire_pop),
    .flush_rob       (flush_rob),
    .uop_rob2dp      (uop_rob2dp)
  );

endmodule
